//--- rv_core.f
logic/rv_core_pkg.sv
logic/inst_decoder.sv
logic/pc_unit.sv
logic/reg_file.sv
logic/alu.sv
logic/csr_unit.sv
logic/load_store_unit.sv
logic/rv_core.sv
dv/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb \
  -f rv_core.f --Mdir obj_dir -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/rv_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

//--- dv/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ;

  localparam logic [31:0] RESET_PC    = 32'h8000_0000;
  localparam logic [31:0] MTVEC_RESET = 32'h8000_0100;
  // trap handler sits well past the end of the main program
  localparam logic [31:0] HANDLER     = RESET_PC + 32'h600;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        dmem_wen;
  logic        dmem_ren;
  logic [31:0] dmem_rdata;
  logic        halt;

  logic [31:0] imem [512];
  logic [31:0] dmem [1024];
  logic [31:0] imem_off;

  // expected pc and load strobe per cycle and expected stores in order
  logic [31:0] pc_trace [1024];
  logic        ren_trace [1024];
  logic [31:0] exp_addr [256];
  logic [31:0] exp_data [256];
  logic [3:0]  exp_strb [256];
  int          n_pc;
  int          pc_idx;
  int          n_exp;
  int          st_idx;
  int          sec_end [4];

  int          errors;
  int          tests_run;
  int          tests_failed;
  logic [31:0] seed;
  logic [31:0] cursor;
  logic [31:0] res_addr;

  rv_core #(.RESET_PC(RESET_PC), .MTVEC_RESET(MTVEC_RESET)) dut_i (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wstrb(dmem_wstrb),
    .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .dmem_rdata(dmem_rdata), .halt(halt)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  assign imem_off   = imem_addr - RESET_PC;
  assign imem_rdata = imem[imem_off[10:2]];
  assign dmem_rdata = dmem[dmem_addr[11:2]];

  always @(posedge clk) begin : dmem_write
    int b;
    for (b = 0; b < 4; b++) begin
      if (dmem_wen && dmem_wstrb[b]) dmem[dmem_addr[11:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_idx <= 0;
      st_idx <= 0;
    end else begin
      if (pc_idx < n_pc) pc_idx <= pc_idx + 1;
      if (dmem_wen) st_idx <= st_idx + 1;
    end
  end

  function automatic logic [31:0] lane_mask(input logic [3:0] s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  // pc_idx stays at zero through reset and the first cycle after it
  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n || pc_idx == 0) |-> !dmem_wen && !dmem_ren && !halt)
    else begin
      errors++;
      $display("store, load or halt raised before the core started");
    end
  a_pc: assert property (@(posedge clk) disable iff (!rst_n)
    pc_idx < n_pc |-> imem_addr == pc_trace[pc_idx])
    else begin
      errors++;
      $display("ERROR imem_addr got %h exp %h", $sampled(imem_addr), pc_trace[$sampled(pc_idx)]);
    end
  a_load_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    pc_idx < n_pc |-> dmem_ren == ren_trace[pc_idx])
    else begin
      errors++;
      $display("ERROR dmem_ren got %h exp %h", $sampled(dmem_ren), ren_trace[$sampled(pc_idx)]);
    end
  a_store_seen: assert property (@(posedge clk) disable iff (!rst_n) dmem_wen |-> st_idx < n_exp)
    else begin
      errors++;
      $display("unexpected store to %h", $sampled(dmem_addr));
    end
  a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wen && st_idx < n_exp |-> dmem_addr == exp_addr[st_idx])
    else begin
      errors++;
      $display("ERROR dmem_addr got %h exp %h", $sampled(dmem_addr), exp_addr[$sampled(st_idx)]);
    end
  a_store_strb: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wen && st_idx < n_exp |-> dmem_wstrb == exp_strb[st_idx])
    else begin
      errors++;
      $display("ERROR dmem_wstrb got %h exp %h", $sampled(dmem_wstrb), exp_strb[$sampled(st_idx)]);
    end
  a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wen && st_idx < n_exp |->
      (dmem_wdata & lane_mask(dmem_wstrb)) == (exp_data[st_idx] & lane_mask(exp_strb[st_idx])))
    else begin
      errors++;
      $display("ERROR dmem_wdata got %h exp %h", $sampled(dmem_wdata), exp_data[$sampled(st_idx)]);
    end
  a_halt_hold: assert property (@(posedge clk) disable iff (!rst_n)
    halt |=> halt && $stable(imem_addr) && !dmem_wen)
    else begin errors++; $display("core moved or stored after halt"); end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
  endfunction

  // RV32I reference rules
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [31:0] w);
    case (f3)
      3'd0:    return {{24{w[7]}}, w[7:0]};
      3'd4:    return {24'd0, w[7:0]};
      3'd1:    return {{16{w[15]}}, w[15:0]};
      3'd5:    return {16'd0, w[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  task automatic place(input logic [31:0] inst, input logic executed);
    logic [31:0] off;
    off = cursor - RESET_PC;
    imem[off[10:2]] = inst;
    if (executed) begin
      pc_trace[n_pc] = cursor;
      ren_trace[n_pc] = inst[6:0] == 7'h03;
      n_pc++;
    end
    cursor += 4;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] hi;
    hi = val + 32'h800;
    place({hi[31:12], rd, 7'h37}, 1'b1);
    place(enc_i(val[11:0], rd, 3'd0, rd, 7'h13), 1'b1);
  endtask

  // store with x0 as base, so the address is the immediate
  task automatic expect_store(input logic [2:0] f3, input logic [4:0] rs, input logic [11:0] a,
                              input logic [31:0] data, input logic [3:0] strb);
    place({a[11:5], rs, 5'd0, f3, a[4:0], 7'h23}, 1'b1);
    exp_addr[n_exp] = {20'd0, a[11:2], 2'b00};
    exp_data[n_exp] = data;
    exp_strb[n_exp] = strb;
    n_exp++;
  endtask

  task automatic check_reg(input logic [4:0] rs, input logic [31:0] val);
    expect_store(3'd2, rs, res_addr[11:0], val, 4'hf);
    res_addr += 4;
  endtask

  task automatic build_alu();
    logic [31:0] a, b, r;
    logic [11:0] imm;
    for (int it = 0; it < 2; it++) begin
      a = next_rand();
      b = next_rand();
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (int f3 = 0; f3 < 8; f3++) begin
        place(enc_r(7'h00, 5'd2, 5'd1, 3'(f3), 5'd3), 1'b1);
        check_reg(5'd3, alu_ref(3'(f3), 1'b0, a, b));
        if (f3 == 0 || f3 == 5) begin
          place(enc_r(7'h20, 5'd2, 5'd1, 3'(f3), 5'd3), 1'b1);
          check_reg(5'd3, alu_ref(3'(f3), 1'b1, a, b));
        end
        r = next_rand();
        imm = r[11:0];
        if (f3 == 1) imm = {7'h00, r[4:0]};
        if (f3 == 5) imm = {(it == 1) ? 7'h20 : 7'h00, r[4:0]};
        place(enc_i(imm, 5'd1, 3'(f3), 5'd4, 7'h13), 1'b1);
        check_reg(5'd4, alu_ref(3'(f3), f3 == 5 && imm[10], a, {{20{imm[11]}}, imm}));
      end
    end
    // writes to x0 are dropped
    place(enc_i(12'h005, 5'd1, 3'd0, 5'd0, 7'h13), 1'b1);
    check_reg(5'd0, 32'd0);
  endtask

  task automatic build_mem();
    logic [31:0] w, v;
    w = fill_word(32'h700);
    for (int o = 0; o < 4; o++) begin
      foreach (sec_end[k]) begin
        logic [2:0] f3;
        f3 = (k == 0) ? 3'd0 : (k == 1) ? 3'd4 : (k == 2) ? 3'd1 : 3'd5;
        if (!f3[0] || o % 2 == 0) begin
          place(enc_i(12'h700 + 12'(o), 5'd0, f3, 5'd5, 7'h03), 1'b1);
          check_reg(5'd5, load_ref(f3, w >> (8 * o)));
        end
      end
    end
    place(enc_i(12'h704, 5'd0, 3'd2, 5'd5, 7'h03), 1'b1);
    check_reg(5'd5, fill_word(32'h704));
    v = next_rand();
    load_const(5'd6, v);
    expect_store(3'd0, 5'd6, res_addr[11:0] + 12'd1, {16'd0, v[7:0], 8'd0}, 4'b0010);
    expect_store(3'd0, 5'd6, res_addr[11:0] + 12'd3, {v[7:0], 24'd0}, 4'b1000);
    expect_store(3'd1, 5'd6, res_addr[11:0] + 12'd2, {v[15:0], 16'd0}, 4'b1100);
    expect_store(3'd1, 5'd6, res_addr[11:0], {16'd0, v[15:0]}, 4'b0011);
    res_addr += 4;
  endtask

  task automatic build_flow();
    logic [31:0] a, b, j, t;
    logic [2:0]  kinds [6];
    int          n;
    kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    a = next_rand();
    b = next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    place(enc_i(12'd0, 5'd0, 3'd0, 5'd9, 7'h13), 1'b1);
    n = 0;
    // each taken branch jumps over one counter increment
    for (int p = 0; p < 3; p++) begin
      foreach (kinds[k]) begin
        t = {31'd0, branch_ref(kinds[k], (p == 1) ? b : a, (p == 0) ? b : a)};
        place(enc_b(13'd8, (p == 0) ? 5'd2 : 5'd1, (p == 1) ? 5'd2 : 5'd1, kinds[k]), 1'b1);
        place(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'h13), !t[0]);
        if (!t[0]) n++;
      end
    end
    check_reg(5'd9, 32'(n));
    j = cursor;
    place({1'b0, 10'd4, 1'b0, 8'd0, 5'd5, 7'h6f}, 1'b1);
    place(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'h13), 1'b0);
    check_reg(5'd5, j + 4);
    // odd target checks that bit 0 is dropped
    t = cursor + 32'd17;
    load_const(5'd6, t);
    j = cursor;
    place(enc_i(12'd0, 5'd6, 3'd0, 5'd7, 7'h67), 1'b1);
    place(enc_i(12'd1, 5'd9, 3'd0, 5'd9, 7'h13), 1'b0);
    check_reg(5'd7, j + 4);
  endtask

  task automatic build_csr();
    logic [31:0] v1, v2, v3, e, ret;
    v1 = next_rand();
    v2 = next_rand();
    v3 = next_rand();
    load_const(5'd6, HANDLER);
    place(enc_i(CSR_MTVEC, 5'd6, 3'd1, 5'd0, 7'h73), 1'b1);
    load_const(5'd1, v1);
    load_const(5'd2, v2);
    load_const(5'd3, v3);
    place(enc_i(CSR_MSTATUS, 5'd1, 3'd1, 5'd12, 7'h73), 1'b1);
    check_reg(5'd12, 32'd0);
    place(enc_i(CSR_MSTATUS, 5'd2, 3'd2, 5'd13, 7'h73), 1'b1);
    check_reg(5'd13, v1);
    place(enc_i(CSR_MSTATUS, 5'd3, 3'd3, 5'd14, 7'h73), 1'b1);
    check_reg(5'd14, v1 | v2);
    place(enc_i(CSR_MSTATUS, 5'd0, 3'd2, 5'd15, 7'h73), 1'b1);
    check_reg(5'd15, (v1 | v2) & ~v3);
    e = cursor;
    place(32'h0000_0073, 1'b1);
    ret = cursor;
    cursor = HANDLER;
    place(enc_i(CSR_MEPC, 5'd0, 3'd2, 5'd10, 7'h73), 1'b1);
    check_reg(5'd10, e);
    place(enc_i(CSR_MCAUSE, 5'd0, 3'd2, 5'd11, 7'h73), 1'b1);
    check_reg(5'd11, ECALL_CAUSE);
    place(enc_i(12'd4, 5'd10, 3'd0, 5'd10, 7'h13), 1'b1);
    place(enc_i(CSR_MEPC, 5'd10, 3'd1, 5'd0, 7'h73), 1'b1);
    place(32'h3020_0073, 1'b1);
    cursor = ret;
    place(enc_i(12'h055, 5'd0, 3'd0, 5'd12, 7'h13), 1'b1);
    check_reg(5'd12, 32'h55);
  endtask

  task automatic report(input string name, input int err_before, input logic done);
    tests_run++;
    if (done && errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d check errors", name, errors - err_before);
    end
  endtask

  task automatic wait_stores(input string name, input int target);
    int cyc;
    int err_before;
    err_before = errors;
    cyc = 0;
    while (st_idx < target && cyc < 500) begin
      @(posedge clk);
      cyc++;
    end
    if (st_idx < target) $display("timeout: %s did not reach its last store", name);
    report(name, err_before, st_idx >= target);
  endtask

  initial begin : main
    int cyc;
    int err_before;
    rst_n = 1'b0;
    seed = 32'hf325e4af;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    n_pc = 0;
    n_exp = 0;
    res_addr = 32'h0;
    for (int i = 0; i < 512; i++) imem[i] = 32'h0010_0073;
    for (int i = 0; i < 1024; i++) dmem[i] <= fill_word(32'(i * 4));
    // first sample after reset still sees the reset pc
    pc_trace[0] = RESET_PC;
    ren_trace[0] = 1'b0;
    n_pc = 1;
    cursor = RESET_PC;
    // a store at the reset pc must stay off the bus until the core runs
    check_reg(5'd0, 32'd0);
    build_alu();
    sec_end[0] = n_exp;
    build_mem();
    sec_end[1] = n_exp;
    build_flow();
    sec_end[2] = n_exp;
    build_csr();
    sec_end[3] = n_exp;
    place(32'h0010_0073, 1'b1);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    err_before = errors;
    cyc = 0;
    while (pc_idx < 2 && cyc < 20) begin
      @(posedge clk);
      cyc++;
    end
    if (pc_idx < 2) $display("timeout: core did not start after reset");
    report("reset", err_before, pc_idx >= 2);

    wait_stores("alu_regfile", sec_end[0]);
    wait_stores("load_store", sec_end[1]);
    wait_stores("control_flow", sec_end[2]);
    wait_stores("csr_trap", sec_end[3]);

    err_before = errors;
    cyc = 0;
    while (!halt && cyc < 200) begin
      @(posedge clk);
      cyc++;
    end
    if (!halt) $display("timeout: halt never rose");
    repeat (10) @(posedge clk);
    report("halt", err_before, halt);

    $display("summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- logic/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
  parameter logic [31:0] RESET_PC    = 32'h8000_0000,
  parameter logic [31:0] MTVEC_RESET = 32'h8000_0100
) (
  input  logic        clk,
  input  logic        rst_n,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_rdata,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic [3:0]  dmem_wstrb,
  output logic        dmem_wen,
  output logic        dmem_ren,
  input  logic [31:0] dmem_rdata,
  output logic        halt
);

  ctrl_t       ctrl;
  logic        run;
  logic [31:0] pc;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] op2;
  logic [31:0] alu_result;
  logic        branch_taken;
  logic [31:0] csr_rdata;
  logic [31:0] trap_target;
  logic [31:0] load_data;
  logic [31:0] wb_data;

  inst_decoder decoder_i (.inst(imem_rdata), .run(run), .ctrl(ctrl));

  pc_unit #(.RESET_PC(RESET_PC)) pc_unit_i (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .alu_result(alu_result),
    .branch_taken(branch_taken), .trap_target(trap_target), .pc(pc), .run(run)
  );

  reg_file reg_file_i (
    .clk(clk), .rst_n(rst_n), .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
    .wen(ctrl.r_wen & run), .wdata(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  always_comb begin
    case (ctrl.op2_sel)
      OP2_IMM: op2 = ctrl.imm;
      OP2_CSR: op2 = csr_rdata;
      default: op2 = rs2_data;
    endcase
  end

  alu alu_i (.op(ctrl.alu_op), .a(rs1_data), .b(op2), .result(alu_result), .taken(branch_taken));

  csr_unit #(.MTVEC_RESET(MTVEC_RESET)) csr_unit_i (
    .clk(clk), .rst_n(rst_n), .ctrl(ctrl), .run(run), .pc(pc), .wdata(alu_result),
    .rdata(csr_rdata), .trap_target(trap_target)
  );

  load_store_unit lsu_i (
    .ctrl(ctrl), .run(run), .addr(alu_result), .store_data(rs2_data),
    .dmem_rdata(dmem_rdata), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
    .dmem_wstrb(dmem_wstrb), .dmem_wen(dmem_wen), .dmem_ren(dmem_ren), .load_data(load_data)
  );

  // SLT and SLTU write back the compare flag
  always_comb begin
    case (ctrl.wb_sel)
      WB_PC4:    wb_data = pc + 32'd4;
      WB_PC_IMM: wb_data = pc + ctrl.imm;
      WB_LOAD:   wb_data = load_data;
      WB_CSR:    wb_data = csr_rdata;
      WB_CMP:    wb_data = {31'd0, branch_taken};
      default:   wb_data = alu_result;
    endcase
  end

  assign imem_addr = pc;
  assign halt      = ctrl.halt;

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit import rv_core_pkg::*; (
  input  ctrl_t       ctrl,
  input  logic        run,
  input  logic [31:0] addr,
  input  logic [31:0] store_data,
  input  logic [31:0] dmem_rdata,
  output logic [31:0] dmem_addr,
  output logic [31:0] dmem_wdata,
  output logic [3:0]  dmem_wstrb,
  output logic        dmem_wen,
  output logic        dmem_ren,
  output logic [31:0] load_data
);

  logic [1:0]  offset;
  logic [3:0]  lanes;
  logic [31:0] shifted;

  assign offset    = addr[1:0];
  assign dmem_addr = {addr[31:2], 2'b00};
  assign dmem_wen  = run & ctrl.mem_wen;
  assign dmem_ren  = run & ctrl.mem_ren;

  always_comb begin
    if (ctrl.mem_byte) begin
      lanes      = 4'b0001 << offset;
      dmem_wdata = {4{store_data[7:0]}};
    end else if (ctrl.mem_half) begin
      lanes      = 4'b0011 << {offset[1], 1'b0};
      dmem_wdata = {2{store_data[15:0]}};
    end else begin
      lanes      = 4'b1111;
      dmem_wdata = store_data;
    end
  end

  assign dmem_wstrb = dmem_wen ? lanes : 4'b0000;

  // bring the addressed lane down to bit 0 then extend
  assign shifted = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    if (ctrl.mem_byte) begin
      load_data = {{24{ctrl.mem_sext & shifted[7]}}, shifted[7:0]};
    end else if (ctrl.mem_half) begin
      load_data = {{16{ctrl.mem_sext & shifted[15]}}, shifted[15:0]};
    end else begin
      load_data = dmem_rdata;
    end
  end

endmodule

//--- logic/csr_unit.sv
`timescale 1ns/1ps

module csr_unit import rv_core_pkg::*; #(
  parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  ctrl_t       ctrl,
  input  logic        run,
  input  logic [31:0] pc,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  output logic [31:0] trap_target
);

  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  logic [11:0] addr;
  logic        wen;
  logic        ecall;

  assign addr  = ctrl.imm[11:0];
  assign wen   = run & ctrl.csr_wen;
  assign ecall = run & ctrl.trap_ecall;

  always_comb begin
    case (addr)
      CSR_MSTATUS: rdata = mstatus;
      CSR_MTVEC:   rdata = mtvec;
      CSR_MEPC:    rdata = mepc;
      CSR_MCAUSE:  rdata = mcause;
      default:     rdata = 32'd0;
    endcase
  end

  // ECALL writes mepc and mcause on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus <= 32'd0;
      mtvec   <= MTVEC_RESET;
      mepc    <= 32'd0;
      mcause  <= 32'd0;
    end else if (ecall) begin
      mepc   <= pc;
      mcause <= ECALL_CAUSE;
    end else if (wen) begin
      case (addr)
        CSR_MSTATUS: mstatus <= wdata;
        CSR_MTVEC:   mtvec   <= wdata;
        CSR_MEPC:    mepc    <= wdata;
        CSR_MCAUSE:  mcause  <= wdata;
        default:     ;
      endcase
    end
  end

  assign trap_target = ctrl.trap_mret ? mepc : mtvec;

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import rv_core_pkg::*; (
  input  logic [7:0]  op,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic [31:0] result,
  output logic        taken
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq  = a == b;
  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  always_comb begin
    case (1'b1)
      op[ALU_SUB]:     result = a - b;
      op[ALU_XOR_EQ]:  result = a ^ b;
      op[ALU_OR_NE]:   result = a | b;
      op[ALU_AND_LTU]: result = a & b;
      op[ALU_SLL_GEU]: result = a << b[4:0];
      op[ALU_SRL_LT]:  result = a >> b[4:0];
      op[ALU_SRA_GE]:  result = $unsigned($signed(a) >>> b[4:0]);
      // clears the rs1 bits out of the CSR value
      op[ALU_ANDN]:    result = b & ~a;
      default:         result = a + b;
    endcase
  end

  // compare outcome paired with the same op bit
  assign taken = (op[ALU_XOR_EQ]  &  eq)
               | (op[ALU_OR_NE]   & ~eq)
               | (op[ALU_AND_LTU] &  ltu)
               | (op[ALU_SLL_GEU] & ~ltu)
               | (op[ALU_SRL_LT]  &  lt)
               | (op[ALU_SRA_GE]  & ~lt);

  always_comb begin
    assert ($onehot0(op))
      else $error("alu op not one-hot: %b", op);
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  // x0 has no storage
  logic [31:0] regs [31:1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  // a write aimed at x0 must not show up on a later read
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (wen && rd == 5'd0) |=> (rs1 != 5'd0 || rs1_data == 32'd0) &&
                            (rs2 != 5'd0 || rs2_data == 32'd0))
    else $error("x0 read back nonzero");

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import rv_core_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  ctrl_t       ctrl,
  input  logic [31:0] alu_result,
  input  logic        branch_taken,
  input  logic [31:0] trap_target,
  output logic [31:0] pc,
  output logic        run
);

  logic        halted;
  logic        advance;
  logic [31:0] pc_plus4;
  logic [31:0] pc_target;
  logic [31:0] next_pc;

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + ctrl.imm;

  always_comb begin
    case (ctrl.npc_sel)
      NPC_JAL:    next_pc = pc_target;
      NPC_JALR:   next_pc = {alu_result[31:1], 1'b0};
      NPC_BRANCH: next_pc = branch_taken ? pc_target : pc_plus4;
      NPC_TRAP:   next_pc = trap_target;
      default:    next_pc = pc_plus4;
    endcase
  end

  // EBREAK holds the pc on itself, so halt stays visible from then on
  assign advance = run & ~halted & ~ctrl.halt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= RESET_PC;
      run    <= 1'b0;
      halted <= 1'b0;
    end else begin
      run <= 1'b1;
      if (ctrl.halt) begin
        halted <= 1'b1;
      end
      if (advance) begin
        pc <= next_pc;
      end
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

//--- logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import rv_core_pkg::*; (
  input  logic [31:0] inst,
  input  logic        run,
  output ctrl_t       ctrl
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        f7_zero;
  logic        f7_alt;

  logic        is_lui, is_auipc, is_jal, is_jalr;
  logic        is_branch, is_load, is_store, is_op_imm, is_op, is_system;
  logic        br_ok, load_ok, store_ok, imm_ok, op_ok, arith;
  logic        csrrw, csrrs, csrrc, is_csr;
  logic        ecall, ebreak, mret;
  logic        set_lt;
  logic        u_type, j_type, b_type, i_type, s_type;
  logic [31:0] imm;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign f7_zero = inst[31:25] == 7'b0000000;
  assign f7_alt  = inst[31:25] == 7'b0100000;

  assign is_lui    = opcode == 7'b01_101_11;
  assign is_auipc  = opcode == 7'b00_101_11;
  assign is_jal    = opcode == 7'b11_011_11;
  assign is_jalr   = opcode == 7'b11_001_11 && funct3 == 3'b000;
  assign is_branch = opcode == 7'b11_000_11;
  assign is_load   = opcode == 7'b00_000_11;
  assign is_store  = opcode == 7'b01_000_11;
  assign is_op_imm = opcode == 7'b00_100_11;
  assign is_op     = opcode == 7'b01_100_11;
  assign is_system = opcode == 7'b11_100_11;

  // funct3 010 and 011 are not branches
  assign br_ok    = is_branch && funct3[2:1] != 2'b01;
  assign load_ok  = is_load && (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
  assign store_ok = is_store && (funct3 inside {3'b000, 3'b001, 3'b010});

  // shifts check funct7, SUB and SRA take the alternate encoding
  assign imm_ok = is_op_imm && (funct3 == 3'b001 ? f7_zero :
                                funct3 == 3'b101 ? (f7_zero | f7_alt) : 1'b1);
  assign op_ok  = is_op && (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
  assign arith  = imm_ok | op_ok;
  assign set_lt = arith && funct3[2:1] == 2'b01;

  assign csrrw  = is_system && funct3 == 3'b001;
  assign csrrs  = is_system && funct3 == 3'b010;
  assign csrrc  = is_system && funct3 == 3'b011;
  assign is_csr = csrrw | csrrs | csrrc;

  assign ecall  = inst == 32'h0000_0073;
  assign ebreak = inst == 32'h0010_0073;
  assign mret   = inst == 32'h3020_0073;

  assign u_type = is_lui | is_auipc;
  assign j_type = is_jal;
  assign b_type = is_branch;
  assign i_type = is_jalr | is_load | is_op_imm | is_csr;
  assign s_type = is_store;

  // only one format is active, so the shapes can be or-ed together
  assign imm = ({32{u_type}} & {inst[31:12], 12'd0})
             | ({32{j_type}} & {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0})
             | ({32{b_type}} & {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0})
             | ({32{i_type}} & {{20{inst[31]}}, inst[31:20]})
             | ({32{s_type}} & {{20{inst[31]}}, inst[31:25], inst[11:7]});

  always_comb begin
    ctrl = '0;
    ctrl.imm = imm;
    // LUI adds the immediate to x0, CSRRW passes rs1 through by adding x0
    ctrl.rs1 = is_lui ? 5'd0 : inst[19:15];
    ctrl.rs2 = csrrw ? 5'd0 : inst[24:20];
    ctrl.rd  = inst[11:7];

    if (ecall || mret)  ctrl.npc_sel = NPC_TRAP;
    else if (br_ok)     ctrl.npc_sel = NPC_BRANCH;
    else if (is_jalr)   ctrl.npc_sel = NPC_JALR;
    else if (is_jal)    ctrl.npc_sel = NPC_JAL;
    else                ctrl.npc_sel = NPC_SEQ;

    if (csrrs || csrrc)                                       ctrl.op2_sel = OP2_CSR;
    else if (is_lui || is_jalr || is_load || is_op_imm || is_store) ctrl.op2_sel = OP2_IMM;
    else                                                      ctrl.op2_sel = OP2_RS2;

    if (is_csr)                  ctrl.wb_sel = WB_CSR;
    else if (is_load)            ctrl.wb_sel = WB_LOAD;
    else if (is_auipc)           ctrl.wb_sel = WB_PC_IMM;
    else if (is_jal || is_jalr)  ctrl.wb_sel = WB_PC4;
    else if (set_lt)             ctrl.wb_sel = WB_CMP;
    else                         ctrl.wb_sel = WB_ALU;

    ctrl.alu_op[ALU_SUB]     = op_ok && funct3 == 3'b000 && f7_alt;
    ctrl.alu_op[ALU_XOR_EQ]  = (arith && funct3 == 3'b100) || (br_ok && funct3 == 3'b000);
    ctrl.alu_op[ALU_OR_NE]   = (arith && funct3 == 3'b110) || (br_ok && funct3 == 3'b001)
                             || csrrs;
    ctrl.alu_op[ALU_AND_LTU] = (arith && (funct3 == 3'b111 || funct3 == 3'b011))
                             || (br_ok && funct3 == 3'b110);
    ctrl.alu_op[ALU_SLL_GEU] = (arith && funct3 == 3'b001) || (br_ok && funct3 == 3'b111);
    ctrl.alu_op[ALU_SRL_LT]  = (arith && ((funct3 == 3'b101 && !f7_alt) || funct3 == 3'b010))
                             || (br_ok && funct3 == 3'b100);
    ctrl.alu_op[ALU_SRA_GE]  = (arith && funct3 == 3'b101 && f7_alt)
                             || (br_ok && funct3 == 3'b101);
    ctrl.alu_op[ALU_ANDN]    = csrrc;

    ctrl.mem_byte = (load_ok || store_ok) && funct3[1:0] == 2'b00;
    ctrl.mem_half = (load_ok || store_ok) && funct3[1:0] == 2'b01;
    ctrl.mem_sext = load_ok && !funct3[2];

    ctrl.r_wen      = u_type | j_type | is_jalr | load_ok | arith | is_csr;
    ctrl.csr_wen    = is_csr;
    ctrl.trap_ecall = ecall;
    ctrl.trap_mret  = mret;

    // nothing reaches memory or halts before the core starts
    ctrl.mem_ren = run & load_ok;
    ctrl.mem_wen = run & store_ok;
    ctrl.halt    = run & ebreak;
  end

  always_comb begin
    assert ($onehot0({ctrl.mem_ren, ctrl.mem_wen, ctrl.halt}))
      else $error("decoder raised more than one of mem_ren, mem_wen, halt");
  end

endmodule

//--- logic/rv_core_pkg.sv
package rv_core_pkg;

  // next-PC source
  typedef enum logic [2:0] {
    NPC_SEQ    = 3'd0,
    NPC_JAL    = 3'd1,
    NPC_JALR   = 3'd2,
    NPC_BRANCH = 3'd3,
    NPC_TRAP   = 3'd4
  } npc_sel_e;

  // register write-back source
  // WB_CMP writes the ALU compare flag for SLT/SLTU
  typedef enum logic [2:0] {
    WB_ALU    = 3'd0,
    WB_PC4    = 3'd1,
    WB_PC_IMM = 3'd2,
    WB_LOAD   = 3'd3,
    WB_CSR    = 3'd4,
    WB_CMP    = 3'd5
  } wb_sel_e;

  // ALU second operand
  typedef enum logic [1:0] {
    OP2_RS2 = 2'd0,
    OP2_IMM = 2'd1,
    OP2_CSR = 2'd2
  } op2_sel_e;

  // one-hot ALU op bits, each bit also names the branch compare it shares
  // no bit set means add
  localparam int ALU_SUB     = 0;
  localparam int ALU_XOR_EQ  = 1;
  localparam int ALU_OR_NE   = 2;
  localparam int ALU_AND_LTU = 3;
  localparam int ALU_SLL_GEU = 4;
  localparam int ALU_SRL_LT  = 5;
  localparam int ALU_SRA_GE  = 6;
  localparam int ALU_ANDN    = 7;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  // environment call from M-mode
  localparam logic [31:0] ECALL_CAUSE = 32'd11;

  typedef struct packed {
    npc_sel_e    npc_sel;
    logic [31:0] imm;
    op2_sel_e    op2_sel;
    logic [7:0]  alu_op;
    logic        mem_byte;
    logic        mem_half;
    logic        mem_sext;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        r_wen;
    wb_sel_e     wb_sel;
    logic        csr_wen;
    logic        trap_ecall;
    logic        trap_mret;
    logic        mem_ren;
    logic        mem_wen;
    logic        halt;
  } ctrl_t;

endpackage
